/* dv/MmuTb.sv */
// MMU testbench

module MmuTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WaitLimit = 200;
    localparam logic [21:0] RootPpn = 22'h00100;
    localparam logic [21:0] TablePpn = 22'h00101;
    localparam logic [7:0] FlagV = 8'h01;
    localparam logic [7:0] FlagR = 8'h02;
    localparam logic [7:0] FlagW = 8'h04;
    localparam logic [7:0] FlagX = 8'h08;

    logic clk = 1'b0;
    logic rst = 1'b1;
    MmuTypes::PhysicalPageNumber satpPpn = RootPpn;
    logic reqValid = 1'b0;
    logic reqReady;
    logic [31:0] reqAddr = '0;
    MmuTypes::MemoryAccessType reqAccessType = MmuTypes::MemoryAccessType_Load;
    logic respValid;
    logic respReady = 1'b1;
    logic [MmuTypes::PhysicalAddrWidth-1:0] respAddr;
    logic respFault;
    MemTypes::MemAddr memAddr;
    logic memReadEnable;
    logic memWriteEnable;
    MemTypes::Line memWriteValue;
    logic memReadDone = 1'b0;
    logic memWriteDone = 1'b0;
    MemTypes::Line memReadValue = '0;

    MemTypes::Line memory [MemTypes::MemAddr];
    MemTypes::Line shadow [MemTypes::MemAddr];
    logic [MmuTypes::PhysicalAddrWidth-1:0] expectAddr [$];
    logic expectFault [$];
    int delaySeed = 66594;
    int stimulusSeed = 66594;
    int memDelay = 0;
    int readCount = 0;
    int sentCount = 0;
    int respCount = 0;

    Mmu u_Mmu (.*);

    always #10 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkAddr(input logic [MmuTypes::PhysicalAddrWidth-1:0] got,
                             input logic [MmuTypes::PhysicalAddrWidth-1:0] expected);
        if (got !== expected) begin
            abortRun($sformatf("** Error: respAddr got %h expected %h", got, expected));
        end
    endtask

    task automatic checkFault(input logic got, input logic expected);
        if (got !== expected) begin
            abortRun($sformatf("** Error: respFault got %h expected %h", got, expected));
        end
    endtask

    task automatic checkLine(input MemTypes::MemAddr addr, input MemTypes::Line got,
                             input MemTypes::Line expected);
        if (got !== expected) begin
            abortRun($sformatf("** Error: memWriteValue at line %h got %h expected %h",
                               addr, got, expected));
        end
    endtask

    // ------------------------------------------------------------------------
    // Page table model

    // Unwritten lines still differ per address
    function automatic MemTypes::Line fillLine(input MemTypes::MemAddr addr);
        return {addr, 2'b10, ~addr};
    endfunction

    function automatic MemTypes::Line memoryLine(input MemTypes::MemAddr addr);
        return memory.exists(addr) ? memory[addr] : fillLine(addr);
    endfunction

    function automatic MemTypes::Line shadowLine(input MemTypes::MemAddr addr);
        return shadow.exists(addr) ? shadow[addr] : fillLine(addr);
    endfunction

    function automatic logic [31:0] makePte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] shadowPte(input logic [33:0] pteAddr);
        MemTypes::Line line;
        line = shadowLine(pteAddr[33:3]);
        return pteAddr[2] ? line[63:32] : line[31:0];
    endfunction

    function automatic void putPte(input logic [33:0] pteAddr, input logic [31:0] pte);
        MemTypes::Line line;
        line = shadowLine(pteAddr[33:3]);
        if (pteAddr[2]) begin
            line[63:32] = pte;
        end else begin
            line[31:0] = pte;
        end
        shadow[pteAddr[33:3]] = line;
    endfunction

    // Sv32 walk over the shadow table that also sets its A and D bits
    function automatic void walkReference(input logic [31:0] vaddr,
                                          input MmuTypes::MemoryAccessType kind,
                                          output logic [33:0] paddr, output logic fault);
        logic [21:0] tablePpn;
        logic [33:0] pteAddr;
        logic [31:0] pte;
        tablePpn = satpPpn;
        paddr = '0;
        fault = 1'b1;
        for (int level = 1; level >= 0; level--) begin
            pteAddr = {tablePpn, (level == 1) ? vaddr[31:22] : vaddr[21:12], 2'b00};
            pte = shadowPte(pteAddr);
            // Invalid, or write without read
            if (!pte[0] || (pte[2] && !pte[1])) begin
                return;
            end
            if (pte[1] || pte[3]) begin
                pte[6] = 1'b1;
                if (kind == MmuTypes::MemoryAccessType_Store) begin
                    pte[7] = 1'b1;
                end
                putPte(pteAddr, pte);
                paddr = (level == 1) ? {pte[31:20], vaddr[21:0]} : {pte[31:10], vaddr[11:0]};
                case (kind)
                    MmuTypes::MemoryAccessType_Instruction: fault = !pte[3];
                    MmuTypes::MemoryAccessType_Load:        fault = !pte[1];
                    default:                                fault = !pte[2];
                endcase
                return;
            end
            tablePpn = pte[31:10];
        end
    endfunction

    task automatic checkMemory();
        foreach (memory[a]) checkLine(a, memory[a], shadowLine(a));
        foreach (shadow[a]) checkLine(a, memoryLine(a), shadow[a]);
    endtask

    // ------------------------------------------------------------------------
    // Line memory with 1 to 4 cycles of latency

    always @(negedge clk) begin
        memReadDone = 1'b0;
        memWriteDone = 1'b0;
        if (rst) begin
            memory = shadow;
            memDelay = 0;
        end else if (memDelay > 0) begin
            memDelay--;
            if (memDelay == 0 && memReadEnable) begin
                memReadValue = memoryLine(memAddr);
                memReadDone = 1'b1;
            end else if (memDelay == 0 && memWriteEnable) begin
                memory[memAddr] = memWriteValue;
                memWriteDone = 1'b1;
            end
        end else if (memReadEnable || memWriteEnable) begin
            memDelay = 1 + int'($unsigned($random(delaySeed)) % 4);
            readCount += int'(memReadEnable);
        end
    end

    // Response compare
    always @(posedge clk) begin
        if (!rst && respValid && respReady) begin
            if (respCount >= sentCount) begin
                abortRun("A response arrived with no request outstanding");
            end
            checkFault(respFault, expectFault[respCount]);
            // Address only means something without a fault
            if (!expectFault[respCount]) begin
                checkAddr(respAddr, expectAddr[respCount]);
            end
            checkMemory();
            respCount++;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus

    task automatic sendRequest(input logic [31:0] vaddr, input MmuTypes::MemoryAccessType kind);
        logic [33:0] paddr;
        logic fault;
        int waited;
        waited = 0;
        while (!reqReady) begin
            @(negedge clk);
            waited++;
            if (waited > WaitLimit) begin
                abortRun("Timeout waiting for reqReady");
            end
        end
        walkReference(vaddr, kind, paddr, fault);
        expectAddr.push_back(paddr);
        expectFault.push_back(fault);
        sentCount++;
        reqValid = 1'b1;
        reqAddr = vaddr;
        reqAccessType = kind;
        @(negedge clk);
        reqValid = 1'b0;
    endtask

    task automatic awaitResponse();
        int waited;
        waited = 0;
        while (respCount != sentCount) begin
            @(negedge clk);
            waited++;
            if (waited > WaitLimit) begin
                abortRun("Timeout waiting for the response to be taken");
            end
        end
    endtask

    task automatic translate(input logic [31:0] vaddr, input MmuTypes::MemoryAccessType kind);
        sendRequest(vaddr, kind);
        awaitResponse();
    endtask

    initial begin
        int reads;
        int waited;
        int pick;
        MmuTypes::MemoryAccessType kind;
        putPte({RootPpn, 10'd2, 2'b00}, makePte({12'h123, 10'h000}, FlagV | FlagR | FlagW));
        putPte({RootPpn, 10'd3, 2'b00}, makePte(TablePpn, FlagV));
        putPte({RootPpn, 10'd5, 2'b00}, 32'h0);
        putPte({TablePpn, 10'd4, 2'b00}, 32'h0);
        putPte({TablePpn, 10'd5, 2'b00}, makePte(22'h0abcd, FlagV | FlagR | FlagX));
        putPte({TablePpn, 10'd6, 2'b00}, makePte(22'h01111, FlagV | FlagW));
        putPte({TablePpn, 10'd7, 2'b00}, makePte(22'h02222, FlagV));
        putPte({TablePpn, 10'd8, 2'b00}, makePte(22'h03333, FlagV | FlagR));
        putPte({TablePpn, 10'd9, 2'b00}, makePte(22'h04444, FlagV | FlagR | FlagW));
        // Eight pages for the eviction run
        for (int i = 0; i < 8; i++) begin
            putPte({TablePpn, 10'(16 + i), 2'b00}, makePte(22'(22'h30000 + i),
                   FlagV | FlagR | (i[0] ? FlagW : 8'h0) | (i[1] ? FlagX : 8'h0)));
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        translate({10'd2, 10'h0a5, 12'h345}, MmuTypes::MemoryAccessType_Load);
        translate({10'd3, 10'd5, 12'habc}, MmuTypes::MemoryAccessType_Load);
        translate({10'd3, 10'd5, 12'h010}, MmuTypes::MemoryAccessType_Instruction);

        // Invalid, write only, level-0 pointer, missing permission
        translate({10'd5, 10'd0, 12'h000}, MmuTypes::MemoryAccessType_Load);
        translate({10'd3, 10'd4, 12'h000}, MmuTypes::MemoryAccessType_Load);
        translate({10'd3, 10'd6, 12'h000}, MmuTypes::MemoryAccessType_Store);
        translate({10'd3, 10'd7, 12'h000}, MmuTypes::MemoryAccessType_Load);
        translate({10'd3, 10'd8, 12'h000}, MmuTypes::MemoryAccessType_Store);
        translate({10'd3, 10'd8, 12'h000}, MmuTypes::MemoryAccessType_Instruction);

        translate({10'd3, 10'd9, 12'h100}, MmuTypes::MemoryAccessType_Load);
        reads = readCount;
        translate({10'd3, 10'd9, 12'h104}, MmuTypes::MemoryAccessType_Load);
        if (readCount != reads) begin
            abortRun("Memory was read for a load that hit the TLB");
        end
        translate({10'd3, 10'd9, 12'h108}, MmuTypes::MemoryAccessType_Store);
        if (readCount == reads) begin
            abortRun("A store to a clean page did not start a walk");
        end

        // Back-pressure on the response channel
        respReady = 1'b0;
        sendRequest({10'd3, 10'd9, 12'h10c}, MmuTypes::MemoryAccessType_Load);
        waited = 0;
        while (!respValid) begin
            @(negedge clk);
            waited++;
            if (waited > WaitLimit) begin
                abortRun("Timeout waiting for respValid");
            end
        end
        repeat (6) begin
            @(negedge clk);
            if (!respValid || reqReady) begin
                abortRun("Response handshake changed while respReady was low");
            end
            checkAddr(respAddr, expectAddr[sentCount - 1]);
        end
        respReady = 1'b1;
        awaitResponse();

        for (int n = 0; n < 200; n++) begin
            pick = int'($unsigned($random(stimulusSeed)) % 8);
            kind = MmuTypes::MemoryAccessType'($unsigned($random(stimulusSeed)) % 3);
            translate({10'd3, 10'(16 + pick), 12'($random(stimulusSeed))}, kind);
        end

        $display("All tests passed");
        $finish;
    end
endmodule

/* hw/MemTypes.sv */
// Line memory types

package MemTypes;

    // 64-bit lines, so two page table entries per line
    localparam int LineWidth = 64;
    localparam int EntryCountInLine = 2;

    // Line address drops the 3 byte offset bits of a 34-bit address
    localparam int MemAddrWidth = 31;

    typedef logic [LineWidth-1:0] Line;
    typedef logic [MemAddrWidth-1:0] MemAddr;

endpackage

/* hw/Mmu.sv */
// Sv32 MMU top level

module Mmu (
    input  logic clk,
    input  logic rst,
    input  MmuTypes::PhysicalPageNumber satpPpn,

    // Request channel
    input  logic reqValid,
    output logic reqReady,
    input  logic [31:0] reqAddr,
    input  MmuTypes::MemoryAccessType reqAccessType,

    // Response channel
    output logic respValid,
    input  logic respReady,
    output logic [MmuTypes::PhysicalAddrWidth-1:0] respAddr,
    output logic respFault,

    // Line memory
    output MemTypes::MemAddr memAddr,
    output logic memReadEnable,
    output logic memWriteEnable,
    output MemTypes::Line memWriteValue,
    input  logic memReadDone,
    input  logic memWriteDone,
    input  MemTypes::Line memReadValue
);
    MemPortIf memPort ();
    WalkIf walkPort ();

    MmuTypes::VirtualPageNumber lookupKey;
    logic lookupHit;
    MmuTypes::TlbEntry lookupEntry;
    logic tlbWriteEnable;
    MmuTypes::VirtualPageNumber tlbWriteKey;
    MmuTypes::TlbEntry tlbWriteValue;

    // ------------------------------------------------------------------------
    // Memory port to plain ports

    assign memAddr = memPort.addr;
    assign memReadEnable = memPort.readEnable;
    assign memWriteEnable = memPort.writeEnable;
    assign memWriteValue = memPort.writeValue;
    assign memPort.readDone = memReadDone;
    assign memPort.writeDone = memWriteDone;
    assign memPort.readValue = memReadValue;

    TranslateStage u_translateStage (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqReady(reqReady),
        .reqAddr(reqAddr), .reqAccessType(reqAccessType),
        .respValid(respValid), .respReady(respReady),
        .respAddr(respAddr), .respFault(respFault),
        .lookupKey(lookupKey), .lookupHit(lookupHit), .lookupEntry(lookupEntry),
        .walk(walkPort.requester)
    );

    Tlb u_tlb (
        .clk(clk), .rst(rst),
        .lookupKey(lookupKey), .lookupHit(lookupHit), .lookupEntry(lookupEntry),
        .writeEnable(tlbWriteEnable), .writeKey(tlbWriteKey), .writeValue(tlbWriteValue)
    );

    TlbReplacer u_tlbReplacer (
        .clk(clk), .rst(rst),
        .mem(memPort.requester),
        .walk(walkPort.walker),
        .satpPpn(satpPpn),
        .tlbWriteEnable(tlbWriteEnable),
        .tlbWriteKey(tlbWriteKey),
        .tlbWriteValue(tlbWriteValue)
    );
endmodule

/* hw/MmuInterfaces.sv */
// Memory port and walk request interfaces

interface MemPortIf;
    MemTypes::MemAddr addr;
    logic readEnable;
    logic writeEnable;
    MemTypes::Line writeValue;
    logic readDone;
    logic writeDone;
    MemTypes::Line readValue;

    modport requester(output addr, readEnable, writeEnable, writeValue,
                      input readDone, writeDone, readValue);
    modport memory(input addr, readEnable, writeEnable, writeValue,
                   output readDone, writeDone, readValue);
endinterface

interface WalkIf;
    logic enable;
    MmuTypes::MemoryAccessType accessType;
    MmuTypes::VirtualPageNumber missPage;
    logic done;

    modport requester(output enable, accessType, missPage, input done);
    modport walker(input enable, accessType, missPage, output done);
endinterface

/* hw/MmuTypes.sv */
// Sv32 translation types

package MmuTypes;

    // ------------------------------------------------------------------------
    // Sizes

    localparam int TlbEntryCount = 4;
    localparam int PageTableEntrySize = 4;
    localparam int PhysicalAddrWidth = 34;

    typedef logic [1:0] TlbIndex;

    // ------------------------------------------------------------------------
    // Page numbers and page table entry

    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } VirtualPageNumber;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0] ppn0;
    } PhysicalPageNumber;

    // Sv32 layout, valid in bit 0
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0] ppn0;
        logic [1:0] rsw;
        logic dirty;
        logic accessed;
        logic globalPage;
        logic user;
        logic execute;
        logic write;
        logic read;
        logic valid;
    } PageTableEntry;

    // ------------------------------------------------------------------------
    // TLB contents

    typedef struct packed {
        logic dirty;
        logic user;
        logic execute;
        logic write;
        logic read;
    } TlbEntryFlags;

    typedef struct packed {
        logic valid;
        logic fault;
        PhysicalPageNumber pageNumber;
        TlbEntryFlags flags;
    } TlbEntry;

    typedef enum logic [1:0] {
        MemoryAccessType_Instruction,
        MemoryAccessType_Load,
        MemoryAccessType_Store
    } MemoryAccessType;

endpackage

/* hw/Tlb.sv */
// Fully associative TLB

module Tlb (
    input  logic clk,
    input  logic rst,
    input  MmuTypes::VirtualPageNumber lookupKey,
    output logic lookupHit,
    output MmuTypes::TlbEntry lookupEntry,
    input  logic writeEnable,
    input  MmuTypes::VirtualPageNumber writeKey,
    input  MmuTypes::TlbEntry writeValue
);
    MmuTypes::VirtualPageNumber keys [MmuTypes::TlbEntryCount];
    MmuTypes::TlbEntry entries [MmuTypes::TlbEntryCount];
    MmuTypes::TlbIndex victim;

    logic writeMatch;
    MmuTypes::TlbIndex writeMatchIndex;
    MmuTypes::TlbIndex writeIndex;

    // Parallel match against valid slots
    always_comb begin
        lookupHit = 1'b0;
        lookupEntry = '0;
        for (int i = 0; i < MmuTypes::TlbEntryCount; i++) begin
            if (entries[i].valid && keys[i] == lookupKey) begin
                lookupHit = 1'b1;
                lookupEntry = entries[i];
            end
        end
    end

    // Same key overwrites its slot and a new key takes the victim
    always_comb begin
        writeMatch = 1'b0;
        writeMatchIndex = '0;
        for (int i = 0; i < MmuTypes::TlbEntryCount; i++) begin
            if (entries[i].valid && keys[i] == writeKey) begin
                writeMatch = 1'b1;
                writeMatchIndex = MmuTypes::TlbIndex'(i);
            end
        end
        writeIndex = writeMatch ? writeMatchIndex : victim;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= '0;
            for (int i = 0; i < MmuTypes::TlbEntryCount; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (writeEnable) begin
            keys[writeIndex] <= writeKey;
            entries[writeIndex] <= writeValue;
            if (!writeMatch) begin
                victim <= victim + 1'b1;
            end
        end
    end
endmodule

/* hw/TlbReplacer.sv */
// Sv32 page table walker

module TlbReplacer (
    input  logic clk,
    input  logic rst,
    MemPortIf.requester mem,
    WalkIf.walker walk,
    input  MmuTypes::PhysicalPageNumber satpPpn,
    output logic tlbWriteEnable,
    output MmuTypes::VirtualPageNumber tlbWriteKey,
    output MmuTypes::TlbEntry tlbWriteValue
);
    typedef logic [$clog2(MemTypes::EntryCountInLine)-1:0] EntryIndex;
    typedef logic [MmuTypes::PhysicalAddrWidth-1:0] EntryAddr;
    typedef MmuTypes::PageTableEntry [MemTypes::EntryCountInLine-1:0] EntryArray;

    typedef enum logic [3:0] {
        StIdle, StRead1, StDecode1, StWrite1,
        StRead0, StDecode0, StWrite0, StTlbWrite, StTlbFault
    } State;

    // ------------------------------------------------------------------------
    // Entry helpers

    function automatic logic isLeaf(MmuTypes::PageTableEntry pte);
        return pte.read || pte.execute;
    endfunction

    function automatic logic isFault(MmuTypes::PageTableEntry pte);
        return !pte.valid || (pte.write && !pte.read);
    endfunction

    function automatic EntryIndex entryIndex(EntryAddr addr);
        return addr[$clog2(MmuTypes::PageTableEntrySize) +: $bits(EntryIndex)];
    endfunction

    function automatic MmuTypes::PageTableEntry pickEntry(MemTypes::Line value, EntryIndex index);
        EntryArray entries;
        entries = value;
        return entries[index];
    endfunction

    function automatic MemTypes::Line replaceEntry(MemTypes::Line value,
                                                   MmuTypes::PageTableEntry pte,
                                                   EntryIndex index);
        EntryArray entries;
        entries = value;
        entries[index] = pte;
        return entries;
    endfunction

    function automatic MmuTypes::TlbEntryFlags flagsOf(MmuTypes::PageTableEntry pte);
        MmuTypes::TlbEntryFlags flags;
        flags.dirty = pte.dirty;
        flags.user = pte.user;
        flags.execute = pte.execute;
        flags.write = pte.write;
        flags.read = pte.read;
        return flags;
    endfunction

    State state;
    State nextState;
    MmuTypes::MemoryAccessType accessType;
    MmuTypes::VirtualPageNumber vpn;
    MmuTypes::PhysicalPageNumber ppn;
    MmuTypes::TlbEntryFlags flags;
    MmuTypes::PageTableEntry pte1;
    MmuTypes::PageTableEntry pte0;
    MemTypes::Line line;

    EntryAddr entryAddr1;
    EntryAddr entryAddr0;
    MmuTypes::PageTableEntry updated1;
    MmuTypes::PageTableEntry updated0;
    logic isStore;
    logic onLevel1;

    assign entryAddr1 = {satpPpn, vpn.vpn1, 2'b00};
    assign entryAddr0 = {pte1.ppn1, pte1.ppn0, vpn.vpn0, 2'b00};
    assign isStore = accessType == MmuTypes::MemoryAccessType_Store;

    // Accessed always set on write back, dirty only for a store
    always_comb begin
        updated1 = pte1;
        updated1.accessed = 1'b1;
        updated1.dirty = pte1.dirty | isStore;
        updated0 = pte0;
        updated0.accessed = 1'b1;
        updated0.dirty = pte0.dirty | isStore;
    end

    // ------------------------------------------------------------------------
    // State transitions

    always_comb begin
        nextState = state;
        case (state)
            StIdle:     if (walk.enable) nextState = StRead1;
            StRead1:    if (mem.readDone) nextState = StDecode1;
            StDecode1: begin
                if (isFault(pte1)) nextState = StTlbFault;
                else if (isLeaf(pte1)) nextState = StWrite1;
                else nextState = StRead0;
            end
            StWrite1:   if (mem.writeDone) nextState = StTlbWrite;
            StRead0:    if (mem.readDone) nextState = StDecode0;
            // No leaf found at the last level
            StDecode0:  nextState = (isFault(pte0) || !isLeaf(pte0)) ? StTlbFault : StWrite0;
            StWrite0:   if (mem.writeDone) nextState = StTlbWrite;
            default:    nextState = StIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == StIdle && walk.enable) begin
            vpn <= walk.missPage;
            accessType <= walk.accessType;
        end
        if (state == StRead1 && mem.readDone) begin
            pte1 <= pickEntry(mem.readValue, entryIndex(entryAddr1));
            line <= mem.readValue;
        end
        if (state == StRead0 && mem.readDone) begin
            pte0 <= pickEntry(mem.readValue, entryIndex(entryAddr0));
            line <= mem.readValue;
        end
        // Megapage takes its low page number from vpn0
        if (state == StDecode1) begin
            ppn <= {updated1.ppn1, vpn.vpn0};
            flags <= flagsOf(updated1);
        end
        if (state == StDecode0) begin
            ppn <= {updated0.ppn1, updated0.ppn0};
            flags <= flagsOf(updated0);
        end
    end

    // ------------------------------------------------------------------------
    // Memory and TLB outputs

    assign onLevel1 = state inside {StRead1, StDecode1, StWrite1};
    assign mem.addr = onLevel1 ?
        entryAddr1[MmuTypes::PhysicalAddrWidth-1 -: MemTypes::MemAddrWidth] :
        entryAddr0[MmuTypes::PhysicalAddrWidth-1 -: MemTypes::MemAddrWidth];
    assign mem.readEnable = state == StRead1 || state == StRead0;
    assign mem.writeEnable = state == StWrite1 || state == StWrite0;
    assign mem.writeValue = onLevel1 ?
        replaceEntry(line, updated1, entryIndex(entryAddr1)) :
        replaceEntry(line, updated0, entryIndex(entryAddr0));

    assign tlbWriteEnable = state == StTlbWrite || state == StTlbFault;
    assign tlbWriteKey = vpn;
    assign walk.done = tlbWriteEnable;

    always_comb begin
        tlbWriteValue.valid = 1'b1;
        tlbWriteValue.fault = state == StTlbFault;
        tlbWriteValue.pageNumber = (state == StTlbFault) ? '0 : ppn;
        tlbWriteValue.flags = (state == StTlbFault) ? '0 : flags;
    end
endmodule

/* hw/TranslateStage.sv */
// Translate request stage

module TranslateStage (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    output logic reqReady,
    input  logic [31:0] reqAddr,
    input  MmuTypes::MemoryAccessType reqAccessType,
    output logic respValid,
    input  logic respReady,
    output logic [MmuTypes::PhysicalAddrWidth-1:0] respAddr,
    output logic respFault,
    output MmuTypes::VirtualPageNumber lookupKey,
    input  logic lookupHit,
    input  MmuTypes::TlbEntry lookupEntry,
    WalkIf.requester walk
);
    typedef enum logic [1:0] { StIdle, StLookup, StWalk, StRespond } State;

    State state;
    logic [31:0] addr;
    MmuTypes::MemoryAccessType accessType;
    logic permitted;
    logic needWalk;

    assign lookupKey = addr[31:12];

    always_comb begin
        case (accessType)
            MmuTypes::MemoryAccessType_Instruction: permitted = lookupEntry.flags.execute;
            MmuTypes::MemoryAccessType_Load:        permitted = lookupEntry.flags.read;
            MmuTypes::MemoryAccessType_Store:       permitted = lookupEntry.flags.write;
            default:                                permitted = 1'b0;
        endcase
    end

    // Store to a clean page walks again to set dirty in memory
    assign needWalk = !lookupHit ||
        (accessType == MmuTypes::MemoryAccessType_Store &&
         !lookupEntry.fault && !lookupEntry.flags.dirty);

    assign walk.enable = state == StLookup && needWalk;
    assign walk.accessType = accessType;
    assign walk.missPage = lookupKey;
    assign reqReady = state == StIdle;
    assign respValid = state == StRespond;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StIdle;
        end else begin
            case (state)
                StIdle:    if (reqValid) state <= StLookup;
                StLookup:  state <= needWalk ? StWalk : StRespond;
                StWalk:    if (walk.done) state <= StLookup;
                default:   if (respReady) state <= StIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == StIdle && reqValid) begin
            addr <= reqAddr;
            accessType <= reqAccessType;
        end
        if (state == StLookup && !needWalk) begin
            respAddr <= {lookupEntry.pageNumber, addr[11:0]};
            respFault <= lookupEntry.fault || !permitted;
        end
    end
endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module MmuTb -f tb.f -o simv || exit 1
./obj_dir/simv 2>&1 | tee sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

/* tb.f */
hw/MmuTypes.sv
hw/MemTypes.sv
hw/MmuInterfaces.sv
hw/TlbReplacer.sv
hw/Tlb.sv
hw/TranslateStage.sv
hw/Mmu.sv
dv/MmuTb.sv
